/* build.f */
+incdir+src
src/cim_pkg.sv
src/twos_to_bipolar.sv
src/bit_plane_piso.sv
src/cim_macro_model.sv
src/seq_ctrl.sv
src/shift_accumulator.sv
src/seq_acc_top.sv
sim/tb_seq_acc.sv

/* Bender.yml */
package:
  name: cim_seq_acc

sources:
  - include_dirs:
      - src
    files:
      - src/cim_pkg.sv
      - src/twos_to_bipolar.sv
      - src/bit_plane_piso.sv
      - src/cim_macro_model.sv
      - src/seq_ctrl.sv
      - src/shift_accumulator.sv
      - src/seq_acc_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/tb_seq_acc.sv

/* sim/tb_seq_acc.sv */
// Directed testbench for the bit-serial CIM MAC accelerator.
// A reference model built from the sign split, column sum, ADC clamp and
// binary weighting rules predicts every result. A monitor compares each
// valid_o pulse against the oldest outstanding prediction.

`timescale 1ns/1ps
`include "cim_consts.svh"

module tb_seq_acc;
    import cim_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int BURST_LEN       = 20;
    localparam int NUM_VECTORS     = 31;
    localparam int WATCHDOG_CYCLES = NUM_VECTORS * 8 + 200;
    localparam int ADC_MAX         = (1 << (`CIM_ADC_BITS - 1)) - 1;
    localparam int ADC_MIN         = -(1 << (`CIM_ADC_BITS - 1));
    localparam int MAG_MAX         = (1 << `CIM_PLANES) - 1;

    logic        clk;
    logic        nrst;
    logic        mac_valid_i;
    mac_in_t     mac_data_i;
    wr_req_t     wr_i;
    logic        ready_o;
    logic        valid_o;
    mac_out_t    mac_data_o;

    // Shadow copy of the weight array
    weight_row_t weights [`CIM_ROWS];
    mac_out_t    exp_q [$];
    mac_out_t    popped;
    int          errors;
    int          checks;
    int          tests;
    int          failed_tests;

    seq_acc_top dut (
        .clk         (clk),
        .nrst        (nrst),
        .mac_valid_i (mac_valid_i),
        .mac_data_i  (mac_data_i),
        .wr_i        (wr_i),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .mac_data_o  (mac_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_mac_out(input string name, input mac_out_t got, input mac_out_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // Every result pulse must match the oldest outstanding prediction
    always @(negedge clk) begin
        if (nrst && valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Result pulse on valid_o with no item outstanding");
            end else begin
                popped = exp_q.pop_front();
                check_mac_out("mac_data_o", mac_data_o, popped);
            end
        end
    end

    function automatic int trit_value(input trit_e t);
        case (t)
            W_POS:   return 1;
            W_NEG:   return -1;
            default: return 0;
        endcase
    endfunction

    function automatic mac_out_t model_mac(input mac_in_t vec);
        mac_out_t res;
        int       mag [`CIM_ROWS];
        int       sgn [`CIM_ROWS];
        int       v;
        int       sum;
        int       code;
        int       total;
        for (int r = 0; r < `CIM_ROWS; r++) begin
            v = $signed(vec[r]);
            sgn[r] = (v < 0) ? -1 : 1;
            mag[r] = (v < 0) ? -v : v;
            // -16 saturates
            if (mag[r] > MAG_MAX) begin
                mag[r] = MAG_MAX;
            end
        end
        for (int c = 0; c < `CIM_COLS; c++) begin
            total = 0;
            for (int k = 0; k < `CIM_PLANES; k++) begin
                sum = 0;
                for (int r = 0; r < `CIM_ROWS; r++) begin
                    if (((mag[r] >> k) & 1) != 0) begin
                        sum += sgn[r] * trit_value(weights[r][c]);
                    end
                end
                code = sum >>> `CIM_ADC_SHIFT;
                if (code > ADC_MAX) begin
                    code = ADC_MAX;
                end
                if (code < ADC_MIN) begin
                    code = ADC_MIN;
                end
                total += code * (1 << k);
            end
            res[c] = acc_word_t'(total * (1 << `CIM_ADC_SHIFT));
        end
        return res;
    endfunction

    function automatic weight_row_t random_row();
        weight_row_t row;
        for (int c = 0; c < `CIM_COLS; c++) begin
            row[c] = trit_e'($urandom_range(2));
        end
        return row;
    endfunction

    function automatic mac_in_t random_vector();
        mac_in_t vec;
        for (int r = 0; r < `CIM_ROWS; r++) begin
            vec[r] = mac_word_t'($urandom);
        end
        return vec;
    endfunction

    // Inputs change a small delay after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_row(input logic [$clog2(`CIM_ROWS)-1:0] row, input weight_row_t data);
        wr_i.en   = 1'b1;
        wr_i.row  = row;
        wr_i.data = data;
        weights[row] = data;
        next_cycle();
        wr_i.en = 1'b0;
    endtask

    task automatic fill_weights(input trit_e t);
        weight_row_t row;
        for (int c = 0; c < `CIM_COLS; c++) begin
            row[c] = t;
        end
        for (int r = 0; r < `CIM_ROWS; r++) begin
            write_row(r, row);
        end
    endtask

    task automatic randomize_weights();
        for (int r = 0; r < `CIM_ROWS; r++) begin
            write_row(r, random_row());
        end
    endtask

    task automatic wait_results(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d results still missing after %0d cycles", exp_q.size(), max_cycles);
            exp_q.delete();
        end
    endtask

    task automatic offer_item(input mac_in_t vec, input mac_out_t exp);
        logic accepted;
        int   n;
        accepted = 1'b0;
        n = 0;
        exp_q.push_back(exp);
        mac_valid_i = 1'b1;
        mac_data_i  = vec;
        while (!accepted && n < 16) begin
            accepted = ready_o;
            next_cycle();
            n++;
        end
        mac_valid_i = 1'b0;
        if (!accepted) begin
            errors++;
            $display("ready_o never rose to accept an item");
        end
        wait_results(16);
    endtask

    task automatic run_item(input mac_in_t vec);
        offer_item(vec, model_mac(vec));
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%-24s ok", name);
        end else begin
            failed_tests++;
            $display("%-24s %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic after_reset();
        int e0;
        e0 = errors;
        check_flag("ready_o", ready_o, 1'b1);
        check_flag("valid_o", valid_o, 1'b0);
        // Zero weights give zero for any input
        offer_item(random_vector(), mac_out_t'(0));
        finish_test("after reset", e0);
    endtask

    task automatic single_items();
        mac_in_t vec;
        int      e0;
        e0 = errors;
        fill_weights(W_POS);
        for (int r = 0; r < `CIM_ROWS; r++) begin
            vec[r] = mac_word_t'($urandom_range(15));
        end
        run_item(vec);
        randomize_weights();
        run_item(random_vector());
        // Full-scale inputs on both signs
        for (int r = 0; r < `CIM_ROWS; r++) begin
            vec[r] = (r % 2 != 0) ? mac_word_t'(15) : mac_word_t'(-16);
        end
        run_item(vec);
        finish_test("single items", e0);
    endtask

    task automatic adc_clamp();
        mac_in_t vec;
        int      e0;
        e0 = errors;
        fill_weights(W_POS);
        // Every plane sums to 16, above the top code
        for (int r = 0; r < `CIM_ROWS; r++) begin
            vec[r] = mac_word_t'(15);
        end
        run_item(vec);
        for (int r = 0; r < `CIM_ROWS; r++) begin
            vec[r] = mac_word_t'(-16);
        end
        run_item(vec);
        finish_test("adc clamp", e0);
    endtask

    task automatic handshake_timing();
        mac_in_t vec;
        int      e0;
        e0 = errors;
        vec = random_vector();
        exp_q.push_back(model_mac(vec));
        check_flag("ready_o", ready_o, 1'b1);
        mac_valid_i = 1'b1;
        mac_data_i  = vec;
        for (int n = 1; n <= 12; n++) begin
            next_cycle();
            check_flag("ready_o", ready_o, n >= 4);
            check_flag("valid_o", valid_o, n == 6);
            // Offer more data while busy, stop before ready returns
            if (n < 4) begin
                mac_data_i = random_vector();
            end else begin
                mac_valid_i = 1'b0;
            end
        end
        wait_results(4);
        finish_test("handshake timing", e0);
    endtask

    task automatic back_to_back();
        mac_in_t vecs [BURST_LEN];
        int      idx;
        int      n;
        int      e0;
        e0 = errors;
        idx = 0;
        n = 0;
        randomize_weights();
        for (int i = 0; i < BURST_LEN; i++) begin
            vecs[i] = random_vector();
            exp_q.push_back(model_mac(vecs[i]));
        end
        mac_valid_i = 1'b1;
        while (idx < BURST_LEN && n < 200) begin
            // Junk while busy must be dropped
            if (ready_o) begin
                mac_data_i = vecs[idx];
                idx++;
            end else begin
                mac_data_i = random_vector();
            end
            next_cycle();
            n++;
        end
        mac_valid_i = 1'b0;
        wait_results(40);
        finish_test("back to back", e0);
    endtask

    task automatic weight_rewrite();
        mac_in_t     vec_a;
        mac_in_t     vec_b;
        weight_row_t row;
        int          e0;
        e0 = errors;
        randomize_weights();
        vec_a = random_vector();
        vec_a[5] = mac_word_t'(7);
        vec_b = random_vector();
        vec_b[5] = mac_word_t'(0);
        run_item(vec_a);
        run_item(vec_b);
        // Row 5 changes in every column, only vec_a sees it
        for (int c = 0; c < `CIM_COLS; c++) begin
            row[c] = (weights[5][c] == W_POS) ? W_NEG : W_POS;
        end
        write_row(5, row);
        run_item(vec_a);
        run_item(vec_b);
        finish_test("weight rewrite", e0);
    endtask

    initial begin
        void'($urandom(32'hffa1_6c67));
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        nrst = 1'b0;
        mac_valid_i = 1'b0;
        mac_data_i = '0;
        wr_i = '0;
        for (int r = 0; r < `CIM_ROWS; r++) begin
            weights[r] = weight_row_t'(0);
        end
        repeat (4) @(posedge clk);
        #2;
        nrst = 1'b1;
        next_cycle();
        after_reset();
        single_items();
        adc_clamp();
        handshake_timing();
        back_to_back();
        weight_rewrite();
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* src/seq_acc_top.sv */
// Top level of the bit-serial CIM MAC accelerator.
// Accepts a 16-element input vector on mac_valid_i while ready_o is
// high and returns four signed column results with a one-cycle valid_o
// pulse six edges later. Weights are written a row at a time via wr_i.

`timescale 1ns/1ps

module seq_acc_top (
    input  logic              clk,
    input  logic              nrst,
    input  logic              mac_valid_i,
    input  cim_pkg::mac_in_t  mac_data_i,
    input  cim_pkg::wr_req_t  wr_i,
    output logic              ready_o,
    output logic              valid_o,
    output cim_pkg::mac_out_t mac_data_o
);
    import cim_pkg::*;

    logic       load;
    logic       mac_en;
    logic       acc_first;
    logic       acc_en;
    plane_set_t planes;
    plane_t     plane;
    adc_codes_t adc_codes;

    seq_ctrl u_seq_ctrl (
        .clk         (clk),
        .nrst        (nrst),
        .mac_valid_i (mac_valid_i),
        .ready_o     (ready_o),
        .load_o      (load),
        .mac_en_o    (mac_en),
        .acc_first_o (acc_first),
        .acc_en_o    (acc_en),
        .valid_o     (valid_o)
    );

    twos_to_bipolar u_twos_to_bipolar (
        .data_i   (mac_data_i),
        .planes_o (planes)
    );

    bit_plane_piso u_bit_plane_piso (
        .clk      (clk),
        .nrst     (nrst),
        .load_i   (load),
        .planes_i (planes),
        .plane_o  (plane)
    );

    cim_macro_model u_cim_macro_model (
        .clk      (clk),
        .nrst     (nrst),
        .wr_i     (wr_i),
        .mac_en_i (mac_en),
        .plane_i  (plane),
        .adc_o    (adc_codes)
    );

    shift_accumulator u_shift_accumulator (
        .clk         (clk),
        .nrst        (nrst),
        .acc_en_i    (acc_en),
        .acc_first_i (acc_first),
        .adc_i       (adc_codes),
        .mac_data_o  (mac_data_o)
    );

endmodule

/* src/shift_accumulator.sv */
// Per-column shift-and-add accumulator for the ADC codes.
// Codes arrive LSB plane first. Each code enters at the top weight and
// the running sum shifts right, so after all planes every column holds
// the sum of code_k * 2^k. The result is scaled back by the ADC shift.

`timescale 1ns/1ps
`include "cim_consts.svh"

module shift_accumulator (
    input  logic                clk,
    input  logic                nrst,
    input  logic                acc_en_i,
    input  logic                acc_first_i,
    input  cim_pkg::adc_codes_t adc_i,
    output cim_pkg::mac_out_t   mac_data_o
);
    import cim_pkg::*;

    mac_out_t acc_q;
    mac_out_t code_term;

    // Sign-extend and weight by the MSB plane position
    always_comb begin
        for (int c = 0; c < `CIM_COLS; c++) begin
            code_term[c] = acc_word_t'($signed(adc_i[c])) <<< (`CIM_PLANES - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            acc_q <= '0;
        end else if (acc_en_i) begin
            for (int c = 0; c < `CIM_COLS; c++) begin
                if (acc_first_i) begin
                    acc_q[c] <= code_term[c];
                end else begin
                    acc_q[c] <= ($signed(acc_q[c]) >>> 1) + code_term[c];
                end
            end
        end
    end

    // Undo the ADC reference range shift
    always_comb begin
        for (int c = 0; c < `CIM_COLS; c++) begin
            mac_data_o[c] = acc_q[c] <<< `CIM_ADC_SHIFT;
        end
    end

    assert property (@(posedge clk) disable iff (!nrst) acc_first_i |-> acc_en_i)
        else $error("acc_first without acc_en");

endmodule

/* src/seq_ctrl.sv */
// Sequencer for the bit-serial MAC pipeline.
// A shift register tracks each accepted item through plane shifting,
// ADC conversion and accumulation. Every control level is decoded from
// the tracker bits, so two items can be in flight at once.

`timescale 1ns/1ps
`include "cim_consts.svh"

module seq_ctrl (
    input  logic clk,
    input  logic nrst,
    input  logic mac_valid_i,
    output logic ready_o,
    output logic load_o,
    output logic mac_en_o,
    output logic acc_first_o,
    output logic acc_en_o,
    output logic valid_o
);

    // One stage per plane plus ADC latency plus result stage
    localparam int STAGES = `CIM_PLANES + 2;

    logic [STAGES-1:0] tracker_q;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            tracker_q <= '0;
        end else begin
            tracker_q <= {tracker_q[STAGES-2:0], load_o};
        end
    end

    // Busy while the PISO still has more than one plane left
    assign ready_o = ~|tracker_q[`CIM_PLANES-2:0];
    assign load_o  = mac_valid_i & ready_o;

    // Planes are presented in the first PLANES stages
    assign mac_en_o = |tracker_q[`CIM_PLANES-1:0];

    // ADC codes trail the planes by one cycle
    assign acc_first_o = tracker_q[1];
    assign acc_en_o    = |tracker_q[`CIM_PLANES:1];

    assign valid_o = tracker_q[STAGES-1];

    assert property (@(posedge clk) disable iff (!nrst) valid_o |=> !valid_o)
        else $error("valid_o high in consecutive cycles");

    // Acceptance needs ready and then blocks the next three cycles
    assert property (@(posedge clk) disable iff (!nrst)
        load_o |-> ready_o ##1 (!ready_o) [*3])
        else $error("acceptance without ready or busy window broken");

endmodule

/* src/cim_macro_model.sv */
// Digital model of the compute-in-memory array and its column ADCs.
// Holds one ternary weight per row and column, written a row at a time.
// With mac_en_i high, each column sums weight x (p - n) over all rows,
// scales by the ADC range shift, clamps to the code range and
// registers the code. Codes hold while mac_en_i is low.

`timescale 1ns/1ps
`include "cim_consts.svh"

module cim_macro_model (
    input  logic                clk,
    input  logic                nrst,
    input  cim_pkg::wr_req_t    wr_i,
    input  logic                mac_en_i,
    input  cim_pkg::plane_t     plane_i,
    output cim_pkg::adc_codes_t adc_o
);
    import cim_pkg::*;

    // Column sum spans -ROWS..ROWS
    localparam int SUM_W   = $clog2(`CIM_ROWS) + 2;
    localparam int ADC_MAX = 2 ** (`CIM_ADC_BITS - 1) - 1;
    localparam int ADC_MIN = -(2 ** (`CIM_ADC_BITS - 1));

    weight_row_t             weights_q [`CIM_ROWS];
    logic signed [SUM_W-1:0] col_sum   [`CIM_COLS];
    logic signed [SUM_W-1:0] scaled    [`CIM_COLS];
    adc_codes_t              code_d;
    adc_codes_t              adc_q;

    // Weight storage
    always_ff @(posedge clk) begin
        if (!nrst) begin
            for (int r = 0; r < `CIM_ROWS; r++) begin
                for (int c = 0; c < `CIM_COLS; c++) begin
                    weights_q[r][c] <= W_ZERO;
                end
            end
        end else if (wr_i.en) begin
            weights_q[wr_i.row] <= wr_i.data;
        end
    end

    // Exact column sums of the current plane
    always_comb begin
        for (int c = 0; c < `CIM_COLS; c++) begin
            col_sum[c] = '0;
            for (int r = 0; r < `CIM_ROWS; r++) begin
                case (weights_q[r][c])
                    W_POS: col_sum[c] = col_sum[c] + SUM_W'(plane_i.p[r])
                                                   - SUM_W'(plane_i.n[r]);
                    W_NEG: col_sum[c] = col_sum[c] - SUM_W'(plane_i.p[r])
                                                   + SUM_W'(plane_i.n[r]);
                    default: col_sum[c] = col_sum[c];
                endcase
            end
        end
    end

    // ADC transfer
    always_comb begin
        for (int c = 0; c < `CIM_COLS; c++) begin
            scaled[c] = col_sum[c] >>> `CIM_ADC_SHIFT;
            if (int'(scaled[c]) > ADC_MAX) begin
                code_d[c] = adc_code_t'(ADC_MAX);
            end else if (int'(scaled[c]) < ADC_MIN) begin
                code_d[c] = adc_code_t'(ADC_MIN);
            end else begin
                code_d[c] = scaled[c][`CIM_ADC_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            adc_q <= '0;
        end else if (mac_en_i) begin
            adc_q <= code_d;
        end
    end

    assign adc_o = adc_q;

    // Weights must be stable while planes are being converted
    assert property (@(posedge clk) disable iff (!nrst) wr_i.en |-> !mac_en_i)
        else $error("weight write during active MAC");

endmodule

/* src/bit_plane_piso.sv */
// Parallel-in serial-out buffer for the input bit-planes.
// All planes load on load_i; otherwise the buffer shifts down by one
// plane per cycle so the array sees LSB first. Zeros fill from the top.

`timescale 1ns/1ps
`include "cim_consts.svh"

module bit_plane_piso (
    input  logic                clk,
    input  logic                nrst,
    input  logic                load_i,
    input  cim_pkg::plane_set_t planes_i,
    output cim_pkg::plane_t     plane_o
);
    import cim_pkg::*;

    plane_set_t planes_q;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            planes_q <= '0;
        end else if (load_i) begin
            planes_q <= planes_i;
        end else begin
            // Drop the plane just consumed
            planes_q <= {plane_t'('0), planes_q[`CIM_PLANES-1:1]};
        end
    end

    assign plane_o = planes_q[0];

endmodule

/* src/twos_to_bipolar.sv */
// Splits a vector of two's-complement inputs into sign-separated
// magnitude bit-planes. Purely combinational, feeds the PISO buffer.
// The most negative input saturates to the largest magnitude.

`timescale 1ns/1ps
`include "cim_consts.svh"

module twos_to_bipolar (
    input  cim_pkg::mac_in_t    data_i,
    output cim_pkg::plane_set_t planes_o
);
    import cim_pkg::*;

    mac_word_t              abs_val [`CIM_ROWS];
    logic [`CIM_PLANES-1:0] mag     [`CIM_ROWS];
    logic [`CIM_ROWS-1:0]   neg;

    always_comb begin
        for (int r = 0; r < `CIM_ROWS; r++) begin
            neg[r] = data_i[r][`CIM_IN_BITS-1];
            abs_val[r] = neg[r] ? (~data_i[r] + 1'b1) : data_i[r];
            // Only -16 leaves the MSB set after negation
            if (abs_val[r][`CIM_IN_BITS-1]) begin
                mag[r] = '1;
            end else begin
                mag[r] = abs_val[r][`CIM_PLANES-1:0];
            end
        end
    end

    // Transpose row magnitudes into per-bit planes
    always_comb begin
        for (int k = 0; k < `CIM_PLANES; k++) begin
            for (int r = 0; r < `CIM_ROWS; r++) begin
                planes_o[k].p[r] = mag[r][k] & ~neg[r];
                planes_o[k].n[r] = mag[r][k] & neg[r];
            end
        end
    end

endmodule

/* src/cim_pkg.sv */
// Shared types for the CIM MAC accelerator.
// Used by every RTL block and the testbench for ports and internal
// signals. Sizes come from the constants header.

`include "cim_consts.svh"

package cim_pkg;

    // One stored ternary weight
    typedef enum logic [1:0] {
        W_ZERO = 2'b00,
        W_POS  = 2'b01,
        W_NEG  = 2'b10
    } trit_e;

    // One array row, a trit per column
    typedef trit_e [`CIM_COLS-1:0] weight_row_t;

    // One bit position of every input, split by sign
    typedef struct packed {
        logic [`CIM_ROWS-1:0] p;
        logic [`CIM_ROWS-1:0] n;
    } plane_t;

    // All magnitude planes of one input vector, plane 0 is the LSB
    typedef plane_t [`CIM_PLANES-1:0] plane_set_t;

    typedef logic signed [`CIM_IN_BITS-1:0] mac_word_t;
    typedef mac_word_t [`CIM_ROWS-1:0] mac_in_t;

    typedef logic signed [`CIM_ADC_BITS-1:0] adc_code_t;
    typedef adc_code_t [`CIM_COLS-1:0] adc_codes_t;

    typedef logic signed [`CIM_ACC_BITS-1:0] acc_word_t;
    typedef acc_word_t [`CIM_COLS-1:0] mac_out_t;

    // Row write request for the weight array
    typedef struct packed {
        logic                          en;
        logic [$clog2(`CIM_ROWS)-1:0]  row;
        weight_row_t                   data;
    } wr_req_t;

endpackage

/* src/cim_consts.svh */
// Size and scaling constants for the compute-in-memory MAC accelerator.
// Include this wherever array dimensions, bit widths or the ADC range
// shift are needed. The package includes it for its type definitions.

`ifndef CIM_CONSTS_SVH
`define CIM_CONSTS_SVH

// Width of one two's-complement input element
`define CIM_IN_BITS 5

// Magnitude bit positions per input, one plane each
`define CIM_PLANES 4

// Inputs per vector, one array row each
`define CIM_ROWS 16

// Output columns of the array
`define CIM_COLS 4

// Signed ADC code width, range -8..7
`define CIM_ADC_BITS 4

// ADC reference range shift, applied to column sums and undone on results
`define CIM_ADC_SHIFT 1

// Signed accumulator and result width
`define CIM_ACC_BITS 10

`endif
